//--- src/lsu_pkg.sv
package lsu_pkg;

    // datapath and line widths
    localparam int XLEN      = 64;
    localparam int LINE_BITS = 128;
    localparam int STRB_BITS = XLEN / 8;

    // cache geometry
    localparam int OFFSET_BITS = 4;                        // 16 bytes per line
    localparam int INDEX_BITS  = 4;
    localparam int CACHE_SETS  = 1 << INDEX_BITS;
    localparam int TAG_BITS    = XLEN - INDEX_BITS - OFFSET_BITS;

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [LINE_BITS-1:0] line_t;
    typedef logic [STRB_BITS-1:0] strb_t;

    // low two bits give the width, bit 2 selects zero extension
    typedef enum logic [2:0] {
        OP_LW   = 3'd0,
        OP_LB   = 3'd1,
        OP_LH   = 3'd2,
        OP_LD   = 3'd3,
        OP_LWU  = 3'd4,
        OP_LBU  = 3'd5,
        OP_LHU  = 3'd6,
        OP_RSVD = 3'd7     // loads as zero, stores as double
    } mem_op_e;

endpackage

//--- src/mem_stage.sv
`timescale 1ns/1ps

module mem_stage
    import lsu_pkg::*;
(
    input  logic    clk,
    input  logic    rst,

    input  logic    access_i,
    input  logic    wen_i,
    input  mem_op_e mem_op_i,
    input  word_t   addr_i,
    input  word_t   wdata_i,
    output logic    busy_o,
    output word_t   rdata_o,

    output logic    req_valid_o,
    output logic    req_we_o,
    output word_t   req_addr_o,
    output word_t   req_wdata_o,
    output strb_t   req_strb_o,
    input  logic    resp_ready_i,
    input  word_t   resp_rdata_i
);

    logic  pending_q;
    logic  done_q;
    word_t rdata_q;

    word_t size_data;
    strb_t size_strb;
    word_t lane;

    // store width from the low two op bits
    always_comb begin
        case (mem_op_i[1:0])
            2'b00: begin
                size_data = {32'b0, wdata_i[31:0]};
                size_strb = 8'h0f;
            end
            2'b01: begin
                size_data = {56'b0, wdata_i[7:0]};
                size_strb = 8'h01;
            end
            2'b10: begin
                size_data = {48'b0, wdata_i[15:0]};
                size_strb = 8'h03;
            end
            default: begin
                size_data = wdata_i;
                size_strb = 8'hff;
            end
        endcase
    end

    // core holds its inputs until busy drops, so the request follows them
    assign req_valid_o = access_i & ~pending_q & ~done_q;
    assign req_we_o    = wen_i;
    assign req_addr_o  = addr_i;
    assign req_wdata_o = size_data << {addr_i[2:0], 3'b000};
    assign req_strb_o  = size_strb << addr_i[2:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            pending_q <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            done_q <= resp_ready_i;                        // one cycle only
            if (resp_ready_i) begin
                pending_q <= 1'b0;
            end else if (req_valid_o) begin
                pending_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (resp_ready_i) begin
            rdata_q <= resp_rdata_i;
        end
    end

    assign busy_o = access_i & ~done_q;

    // addressed bytes down to lane 0
    assign lane = rdata_q >> {addr_i[2:0], 3'b000};

    always_comb begin
        rdata_o = '0;
        case (mem_op_i)
            OP_LW:   rdata_o = {{32{lane[31]}}, lane[31:0]};
            OP_LB:   rdata_o = {{56{lane[7]}}, lane[7:0]};
            OP_LH:   rdata_o = {{48{lane[15]}}, lane[15:0]};
            OP_LD:   rdata_o = lane;
            OP_LWU:  rdata_o = {32'b0, lane[31:0]};
            OP_LBU:  rdata_o = {56'b0, lane[7:0]};
            OP_LHU:  rdata_o = {48'b0, lane[15:0]};
            OP_RSVD: rdata_o = '0;
            default: rdata_o = '0;
        endcase
    end

endmodule

//--- src/dcache.sv
`timescale 1ns/1ps

module dcache
    import lsu_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    input  logic  req_valid_i,
    input  logic  req_we_i,
    input  word_t req_addr_i,
    input  word_t req_wdata_i,
    input  strb_t req_strb_i,
    output logic  resp_ready_o,
    output word_t resp_rdata_o,

    output logic  mem_valid_o,
    output logic  mem_we_o,
    output word_t mem_addr_o,
    output line_t mem_wdata_o,
    input  line_t mem_rdata_i,
    input  logic  mem_ready_i
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_WRITEBACK,
        S_REFILL,
        S_RESPOND
    } state_e;

    state_e state_q;
    state_e state_d;

    line_t                data_arr [CACHE_SETS];
    logic [TAG_BITS-1:0]  tag_arr  [CACHE_SETS];
    logic [CACHE_SETS-1:0] valid_q;
    logic [CACHE_SETS-1:0] dirty_q;

    // request captured on accept
    logic  req_we_q;
    word_t req_addr_q;
    word_t req_wdata_q;
    strb_t req_strb_q;

    logic [INDEX_BITS-1:0] idx;
    logic [TAG_BITS-1:0]   req_tag;
    logic                  hit;
    logic                  access;

    assign idx     = req_addr_q[OFFSET_BITS +: INDEX_BITS];
    assign req_tag = req_addr_q[XLEN-1 -: TAG_BITS];
    assign hit     = valid_q[idx] && (tag_arr[idx] == req_tag);

    // line is resident this cycle, read or merge it
    assign access = (state_q == S_LOOKUP && hit) || (state_q == S_RESPOND);

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (req_valid_i) begin
                    state_d = S_LOOKUP;
                end
            end
            S_LOOKUP: begin
                if (hit) begin
                    state_d = S_IDLE;
                end else if (valid_q[idx] && dirty_q[idx]) begin
                    state_d = S_WRITEBACK;
                end else begin
                    state_d = S_REFILL;
                end
            end
            S_WRITEBACK: begin
                if (mem_ready_i) begin
                    state_d = S_REFILL;
                end
            end
            S_REFILL: begin
                if (mem_ready_i) begin
                    state_d = S_RESPOND;
                end
            end
            S_RESPOND: state_d = S_IDLE;
            default:   state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_IDLE;
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == S_REFILL && mem_ready_i) begin
                valid_q[idx] <= 1'b1;
                dirty_q[idx] <= 1'b0;                      // fresh line
            end
            if (access && req_we_q) begin
                dirty_q[idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && req_valid_i) begin
            req_we_q    <= req_we_i;
            req_addr_q  <= req_addr_i;
            req_wdata_q <= req_wdata_i;
            req_strb_q  <= req_strb_i;
        end
        if (state_q == S_REFILL && mem_ready_i) begin
            data_arr[idx] <= mem_rdata_i;
            tag_arr[idx]  <= req_tag;
        end
        if (access && req_we_q) begin
            // masked bytes into the addressed half
            for (int b = 0; b < STRB_BITS; b++) begin
                if (req_strb_q[b]) begin
                    data_arr[idx][{req_addr_q[3], b[2:0], 3'b000} +: 8] <=
                        req_wdata_q[b*8 +: 8];
                end
            end
        end
    end

    assign resp_ready_o = access;
    assign resp_rdata_o = req_addr_q[3] ? data_arr[idx][LINE_BITS-1:XLEN]
                                        : data_arr[idx][XLEN-1:0];

    // line port, held by state until ready
    assign mem_valid_o = (state_q == S_WRITEBACK) || (state_q == S_REFILL);
    assign mem_we_o    = (state_q == S_WRITEBACK);
    assign mem_addr_o  = (state_q == S_WRITEBACK)
                       ? {tag_arr[idx], idx, {OFFSET_BITS{1'b0}}}   // victim
                       : {req_tag, idx, {OFFSET_BITS{1'b0}}};
    assign mem_wdata_o = data_arr[idx];

endmodule

//--- src/lsu_top.sv
`timescale 1ns/1ps

module lsu_top
    import lsu_pkg::*;
(
    input  logic    clk,
    input  logic    rst,

    input  logic    access_i,
    input  logic    wen_i,
    input  mem_op_e mem_op_i,
    input  word_t   addr_i,
    input  word_t   wdata_i,
    output logic    busy_o,
    output word_t   rdata_o,

    output logic    mem_valid_o,
    output logic    mem_we_o,
    output word_t   mem_addr_o,
    output line_t   mem_wdata_o,
    input  line_t   mem_rdata_i,
    input  logic    mem_ready_i
);

    // stage to cache
    logic  req_valid;
    logic  req_we;
    word_t req_addr;
    word_t req_wdata;
    strb_t req_strb;
    logic  resp_ready;
    word_t resp_rdata;

    mem_stage u_mem_stage (
        .clk          (clk),
        .rst          (rst),
        .access_i     (access_i),
        .wen_i        (wen_i),
        .mem_op_i     (mem_op_i),
        .addr_i       (addr_i),
        .wdata_i      (wdata_i),
        .busy_o       (busy_o),
        .rdata_o      (rdata_o),
        .req_valid_o  (req_valid),
        .req_we_o     (req_we),
        .req_addr_o   (req_addr),
        .req_wdata_o  (req_wdata),
        .req_strb_o   (req_strb),
        .resp_ready_i (resp_ready),
        .resp_rdata_i (resp_rdata)
    );

    dcache u_dcache (
        .clk          (clk),
        .rst          (rst),
        .req_valid_i  (req_valid),
        .req_we_i     (req_we),
        .req_addr_i   (req_addr),
        .req_wdata_i  (req_wdata),
        .req_strb_i   (req_strb),
        .resp_ready_o (resp_ready),
        .resp_rdata_o (resp_rdata),
        .mem_valid_o  (mem_valid_o),
        .mem_we_o     (mem_we_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_rdata_i  (mem_rdata_i),
        .mem_ready_i  (mem_ready_i)
    );

endmodule

//--- verification/ext_mem.sv
`timescale 1ns/1ps

module ext_mem
    import lsu_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    input  logic  mem_valid_i,
    input  logic  mem_we_i,
    input  word_t mem_addr_i,
    input  line_t mem_wdata_i,
    output line_t mem_rdata_o,
    output logic  mem_ready_o
);

    line_t lines [word_t];                                 // only lines written so far
    logic  busy_q;
    int    wait_q;

    // byte a holds low bits of 7a+3 until written
    function automatic logic [7:0] fill_byte(input word_t a);
        word_t v;
        v = a * 64'd7 + 64'd3;
        return v[7:0];
    endfunction

    function automatic line_t read_line(input word_t a);
        line_t l;
        l = '0;
        if (lines.exists(a)) begin
            l = lines[a];
        end else begin
            for (int k = 0; k < LINE_BITS / 8; k++) begin
                l = l | (line_t'(fill_byte(a + word_t'(k))) << (k * 8));
            end
        end
        return l;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            busy_q      <= 1'b0;
            wait_q      <= 0;
            mem_ready_o <= 1'b0;
            mem_rdata_o <= '0;
        end else begin
            mem_ready_o <= 1'b0;
            if (busy_q) begin
                if (wait_q == 1) begin
                    busy_q      <= 1'b0;
                    mem_ready_o <= 1'b1;
                    if (mem_we_i) begin
                        lines[mem_addr_i] = mem_wdata_i;
                    end else begin
                        mem_rdata_o <= read_line(mem_addr_i);
                    end
                end else begin
                    wait_q <= wait_q - 1;
                end
            end else if (mem_valid_i && !mem_ready_o) begin
                // new transfer, answer after 1 to 4 cycles
                busy_q <= 1'b1;
                wait_q <= int'($urandom_range(4, 1));
            end
        end
    end

endmodule

//--- verification/tb_lsu_top.sv
`timescale 1ns/1ps

module tb_lsu_top
    import lsu_pkg::*;
();

    localparam word_t BASE_ADDR       = 64'h0000_0000_8000_0000;
    localparam int    WINDOW_BYTES    = 1024;              // 64 lines
    localparam int    RANDOM_ACCESSES = 2000;
    localparam int    TIMEOUT_CYCLES  = 40000;

    logic    clk;
    logic    rst;
    logic    access;
    logic    wen;
    mem_op_e mem_op;
    word_t   addr;
    word_t   wdata;
    logic    busy;
    word_t   rdata;
    logic    mem_valid;
    logic    mem_we;
    word_t   mem_addr;
    line_t   mem_wdata;
    line_t   mem_rdata;
    logic    mem_ready;

    logic [7:0] model_mem [WINDOW_BYTES];
    int         cycle_count;
    int         wb_count;

    // line port request seen at the last falling edge
    logic       held_valid;
    logic       held_we;
    word_t      held_addr;
    line_t      held_wdata;

    lsu_top UUT (
        .clk         (clk),
        .rst         (rst),
        .access_i    (access),
        .wen_i       (wen),
        .mem_op_i    (mem_op),
        .addr_i      (addr),
        .wdata_i     (wdata),
        .busy_o      (busy),
        .rdata_o     (rdata),
        .mem_valid_o (mem_valid),
        .mem_we_o    (mem_we),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_rdata_i (mem_rdata),
        .mem_ready_i (mem_ready)
    );

    ext_mem u_ext_mem (
        .clk         (clk),
        .rst         (rst),
        .mem_valid_i (mem_valid),
        .mem_we_i    (mem_we),
        .mem_addr_i  (mem_addr),
        .mem_wdata_i (mem_wdata),
        .mem_rdata_o (mem_rdata),
        .mem_ready_o (mem_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_and_stop();
        $display("Result: FAILED");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            fail_and_stop();
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
            fail_and_stop();
        end
    endtask

    task automatic check_line(input string name, input line_t expected, input line_t actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            fail_and_stop();
        end
    endtask

    function automatic logic [7:0] initial_byte(input word_t a);
        word_t v;
        v = a * 64'd7 + 64'd3;
        return v[7:0];
    endfunction

    function automatic int access_size(input mem_op_e op);
        case (op)
            OP_LB, OP_LBU: return 1;
            OP_LH, OP_LHU: return 2;
            OP_LW, OP_LWU: return 4;
            default:       return 8;                       // double and reserved
        endcase
    endfunction

    function automatic word_t model_load(input mem_op_e op, input word_t a);
        logic [9:0] pos;
        word_t      raw;
        int         size;
        int         sh;
        raw  = '0;
        size = access_size(op);
        sh   = 64 - size * 8;
        for (int i = 0; i < size; i++) begin
            pos = 10'(a - BASE_ADDR + word_t'(i));
            raw = raw | (word_t'(model_mem[pos]) << (i * 8));
        end
        if (op == OP_RSVD) begin
            raw = '0;
        end else if (op == OP_LB || op == OP_LH || op == OP_LW) begin
            raw = word_t'($signed(raw << sh) >>> sh);      // copy top loaded bit upward
        end
        return raw;
    endfunction

    function automatic void model_store(input mem_op_e op, input word_t a, input word_t data);
        logic [9:0] pos;
        for (int i = 0; i < access_size(op); i++) begin
            pos = 10'(a - BASE_ADDR + word_t'(i));
            model_mem[pos] = 8'(data >> (i * 8));
        end
    endfunction

    // one access from a falling edge until busy drops, access left low after
    task automatic run_access(input string name, input logic we, input mem_op_e op,
                              input word_t a, input word_t data, output int cycles);
        word_t expected;
        @(negedge clk);
        access   = 1'b1;
        wen      = we;
        mem_op   = op;
        addr     = a;
        wdata    = data;
        expected = model_load(op, a);
        @(negedge clk);
        cycles = 1;
        while (busy) begin
            @(negedge clk);
            cycles++;
        end
        if (we) begin
            model_store(op, a, data);
        end else begin
            check_word(name, expected, rdata);
        end
        access = 1'b0;
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (!rst && mem_valid && mem_we && mem_ready) begin
            wb_count <= wb_count + 1;
        end
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: no end of test after %0d cycles", TIMEOUT_CYCLES);
            fail_and_stop();
        end
    end

    // a line transfer holds address, direction and write data until ready
    always @(negedge clk) begin
        if (held_valid) begin
            check_bit("mem_valid_hold", 1'b1, mem_valid);
            check_word("mem_addr_hold", held_addr, mem_addr);
            check_bit("mem_we_hold", held_we, mem_we);
            if (held_we) begin
                check_line("mem_wdata_hold", held_wdata, mem_wdata);
            end
        end
        if (!rst && mem_valid) begin
            check_word("mem_addr_align", 64'h0, {60'b0, mem_addr[3:0]});
        end
        held_valid = !rst && mem_valid && !mem_ready;
        held_we    = mem_we;
        held_addr  = mem_addr;
        held_wdata = mem_wdata;
    end

    initial begin
        mem_op_e    op;
        logic [2:0] op_bits;
        logic       we;
        word_t      a;
        int         cycles;
        int         off;
        int         wb_before;
        mem_op_e    store_ops [4];
        word_t      store_offs [4];

        void'($urandom(32'hbab8));
        cycle_count = 0;
        wb_count    = 0;
        held_valid  = 1'b0;
        rst    = 1'b1;
        access = 1'b0;
        wen    = 1'b0;
        mem_op = OP_LD;
        addr   = BASE_ADDR;
        wdata  = '0;
        for (int i = 0; i < WINDOW_BYTES; i++) begin
            model_mem[10'(i)] = initial_byte(BASE_ADDR + word_t'(i));
        end
        repeat (5) @(negedge clk);
        rst = 1'b0;

        @(negedge clk);
        check_bit("reset_mem_valid", 1'b0, mem_valid);
        check_bit("reset_busy", 1'b0, busy);

        // all load codes at every aligned offset of both halves of a line
        for (int h = 0; h < 2; h++) begin
            for (int k = 0; k < 8; k++) begin
                op = mem_op_e'(3'(k));
                for (int o = 0; o < 8; o += access_size(op)) begin
                    a = BASE_ADDR + 64'h40 + word_t'(h * 8 + o);
                    run_access("load_widths", 1'b0, op, a, '0, cycles);
                end
            end
        end

        store_ops  = '{OP_LB, OP_LH, OP_LW, OP_LD};
        store_offs = '{64'h10d, 64'h10a, 64'h10c, 64'h108};
        for (int s = 0; s < 4; s++) begin
            a = BASE_ADDR + store_offs[s];
            run_access("store_width", 1'b1, store_ops[s], a, {$urandom, $urandom}, cycles);
            run_access("store_same", 1'b0, OP_LD, BASE_ADDR + 64'h108, '0, cycles);
            run_access("store_prev", 1'b0, OP_LD, BASE_ADDR + 64'h100, '0, cycles);
            run_access("store_next", 1'b0, OP_LD, BASE_ADDR + 64'h110, '0, cycles);
            run_access("store_narrow", 1'b0, store_ops[s], a, '0, cycles);
        end

        // index 3 under four tags
        wb_before = wb_count;
        for (int r = 0; r < 2; r++) begin
            for (int t = 0; t < 4; t++) begin
                a = BASE_ADDR + word_t'((t * 16 + 3) * 16 + r * 8);
                run_access("evict_store", 1'b1, OP_LD, a, {$urandom, $urandom}, cycles);
            end
        end
        for (int t = 0; t < 4; t++) begin
            a = BASE_ADDR + word_t'((t * 16 + 3) * 16);
            run_access("evict_load_lo", 1'b0, OP_LD, a, '0, cycles);
            run_access("evict_load_hi", 1'b0, OP_LD, a + 64'h8, '0, cycles);
        end
        check_bit("evict_writeback", 1'b1, wb_count > wb_before);

        a = BASE_ADDR + 64'h2c0;
        run_access("repeat_warm", 1'b0, OP_LD, a, '0, cycles);
        run_access("repeat_load", 1'b0, OP_LD, a, '0, cycles);
        check_word("repeat_load_cycles", word_t'(2), word_t'(cycles));
        run_access("repeat_store", 1'b1, OP_LW, a + 64'h4, {$urandom, $urandom}, cycles);
        check_word("repeat_store_cycles", word_t'(2), word_t'(cycles));
        run_access("repeat_half", 1'b0, OP_LWU, a + 64'hc, '0, cycles);
        check_word("repeat_half_cycles", word_t'(2), word_t'(cycles));

        for (int n = 0; n < RANDOM_ACCESSES; n++) begin
            op_bits = 3'($urandom);
            op      = mem_op_e'(op_bits);
            we      = 1'($urandom);
            off     = int'($urandom_range(WINDOW_BYTES - 1, 0));
            off     = off - (off % access_size(op));       // natural alignment
            a       = BASE_ADDR + word_t'(off);
            run_access("random_mix", we, op, a, {$urandom, $urandom}, cycles);
        end

        @(negedge clk);
        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- lsu_top.f
src/lsu_pkg.sv
src/mem_stage.sv
src/dcache.sv
src/lsu_top.sv
verification/ext_mem.sv
verification/tb_lsu_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_lsu_top
FILELIST  ?= lsu_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# a failing run returns non-zero through $fatal
run: compile
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
